// File: Bender.yml
package:
  name: jesd_link_ctl

sources:
  # RTL, package and interface first
  - target: rtl
    files:
      - src/jesd_ctl_pkg.sv
      - src/gt_reset_if.sv
      - src/phy_reset_seq.sv
      - src/link_reset_ctl.sv
      - src/phy_ready_filter.sv
      - src/lane_status_select.sv
      - src/jesd_link_ctl.sv

  # Simulation bench
  - target: test
    files:
      - bench/tb_clock_gen.sv
      - bench/tb_jesd_link_ctl.sv

// File: bench/tb_clock_gen.sv
// Bench clock and PLL lock source, 8 ns clock with lock held low for the first 8 cycles
`timescale 1ns/100ps

module tb_clock_gen (
	output logic clk_o,
	output logic pll_locked_o
);

	localparam int HALF_PERIOD_NS = 4;
	localparam int RESET_CYCLES   = 8;

	initial begin
		clk_o = 1'b0;
		forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
	end

	initial begin
		pll_locked_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		// Lock comes between edges, like every other input
		@(negedge clk_o);
		pll_locked_o = 1'b1;
	end

endmodule

// File: bench/tb_jesd_link_ctl.sv
// Simulation top for the link control block that drives each phase and checks outputs against bench models
`timescale 1ns/100ps

module tb_jesd_link_ctl;

	import jesd_ctl_pkg::*;

	// Release-edge numbers where each reset window is high
	localparam int SYS_FIRST_EDGE  = 101;
	localparam int SYS_LAST_EDGE   = 111;
	localparam int DATA_FIRST_EDGE = 201;
	localparam int DATA_LAST_EDGE  = 211;
	localparam int RST_CNT_MAX     = 65535;
	localparam int READY_SAT       = 63;

	////////////////////////////////
	// Phase lengths and timeout
	////////////////////////////////

	localparam int READY_BURSTS  = 12;
	localparam int STATUS_CYCLES = 320;
	localparam int PH_RESET      = 10;
	localparam int PH_WINDOW     = 240 + 4 + 105 + 3 + 240;
	localparam int PH_LINK       = 10 + 3 * 12;
	// Longest stretch 119 plus longest gap 3
	localparam int PH_READY      = READY_BURSTS * 122;
	localparam int PH_STATUS     = STATUS_CYCLES + 4;
	localparam int TIMEOUT_CYCLES = PH_RESET + PH_WINDOW + PH_LINK + PH_READY + PH_STATUS + 500;

	logic                                   rst_ctl_clk;
	logic                                   pll_locked;
	logic                                   gt_powergood_i;
	logic                                   tx_reset_done_i;
	logic                                   rx_reset_done_i;
	logic                                   gt_sys_reset_o;
	logic                                   gt_data_reset_o;
	logic                                   link_reset_b_o;
	logic [NUM_LANES-1:0]                   tx_ready_i;
	logic [NUM_LANES-1:0]                   rx_ready_i;
	logic                                   phy_ready_o;
	logic [CHAN_W-1:0]                      rx_channel_i;
	logic [NUM_LANES-1:0][USEDW_W-1:0]      lane_usedw_i;
	logic [NUM_LANES-1:0][ERR_CNT_W-1:0]    lane_err_i;
	logic [USEDW_W-1:0]                     usedw_o;
	logic [ERR_CNT_W-1:0]                   err_link_rx_o;

	// Bench models
	logic                 rst_seen  = 1'b0;
	logic [1:0]           lock_hist = 2'b00;
	int                   rel_edges = 0;
	int                   ready_run = 0;
	logic [2:0]           link_pipe = '0;
	logic                 exp_sys   = 1'b0;
	logic                 exp_data  = 1'b0;
	logic [USEDW_W-1:0]   exp_usedw = '0;
	logic [ERR_CNT_W-1:0] exp_err   = '0;

	int seed      = 50;
	int errors    = 0;
	int checks    = 0;
	int cycle_cnt = 0;

	tb_clock_gen clock_gen (
		.clk_o        (rst_ctl_clk),
		.pll_locked_o (pll_locked)
	);

	jesd_link_ctl UUT (
		.rst_ctl_clk     (rst_ctl_clk),
		.pll_locked      (pll_locked),
		.gt_powergood_i  (gt_powergood_i),
		.tx_reset_done_i (tx_reset_done_i),
		.rx_reset_done_i (rx_reset_done_i),
		.gt_sys_reset_o  (gt_sys_reset_o),
		.gt_data_reset_o (gt_data_reset_o),
		.link_reset_b_o  (link_reset_b_o),
		.tx_ready_i      (tx_ready_i),
		.rx_ready_i      (rx_ready_i),
		.phy_ready_o     (phy_ready_o),
		.rx_channel_i    (rx_channel_i),
		.lane_usedw_i    (lane_usedw_i),
		.lane_err_i      (lane_err_i),
		.usedw_o         (usedw_o),
		.err_link_rx_o   (err_link_rx_o)
	);

	function automatic int rand_between(input int lo, input int hi);
		return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
	endfunction

	// Code n selects lane n-1 and other codes select no lane
	function automatic int lane_of_code(input logic [CHAN_W-1:0] code);
		if (code >= 1 && code <= NUM_LANES) begin
			return int'(code) - 1;
		end
		return -1;
	endfunction

	task automatic report_mismatch(input string test, input logic [31:0] expected,
			input logic [31:0] actual);
		errors++;
		$display("FAILED %s expected 0x%0h actual 0x%0h at %0t",
			test, expected, actual, $time);
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge rst_ctl_clk);
	endtask

	////////////////////////////////
	// Reference model
	////////////////////////////////

	always @(posedge rst_ctl_clk) begin : reference_model
		int rel_next;
		int run_next;
		int lane;
		cycle_cnt <= cycle_cnt + 1;
		lock_hist <= {lock_hist[0], pll_locked};
		if (!pll_locked) begin
			rst_seen  <= 1'b1;
			rel_edges <= 0;
			ready_run <= 0;
			link_pipe <= '0;
			exp_sys   <= 1'b0;
			exp_data  <= 1'b0;
			exp_usedw <= '0;
			exp_err   <= '0;
		end else begin
			// Release edges counted only while power is good
			if (!gt_powergood_i) begin
				rel_next = 0;
			end else if (rel_edges < RST_CNT_MAX) begin
				rel_next = rel_edges + 1;
			end else begin
				rel_next = rel_edges;
			end
			rel_edges <= rel_next;
			exp_sys   <= (rel_next >= SYS_FIRST_EDGE) && (rel_next <= SYS_LAST_EDGE);
			exp_data  <= (rel_next >= DATA_FIRST_EDGE) && (rel_next <= DATA_LAST_EDGE);

			run_next  = ((&tx_ready_i) && (&rx_ready_i)) ?
				((ready_run < READY_SAT) ? ready_run + 1 : READY_SAT) : 0;
			ready_run <= run_next;

			// Link reset follows the AND of the three flags three edges late
			link_pipe <= {link_pipe[1:0], tx_reset_done_i & rx_reset_done_i & gt_powergood_i};

			lane = lane_of_code(rx_channel_i);
			if (link_pipe[2] && link_pipe[1] && lane >= 0) begin
				exp_usedw <= lane_usedw_i[lane];
				exp_err   <= lane_err_i[lane];
			end else begin
				exp_usedw <= '0;
				exp_err   <= '0;
			end
		end
	end

	////////////////////////////////
	// Output checks on the falling edge
	////////////////////////////////

	always @(negedge rst_ctl_clk) begin
		if (rst_seen) begin
			checks += 6;
			if (lock_hist != 2'b11) begin
				checks += 3;
				assert ({gt_sys_reset_o, gt_data_reset_o, link_reset_b_o, phy_ready_o} === 4'b0000)
					else report_mismatch("reset_state_ctl", 32'h0,
						{gt_sys_reset_o, gt_data_reset_o, link_reset_b_o, phy_ready_o});
				assert (usedw_o === '0)
					else report_mismatch("reset_state_usedw", 32'h0, usedw_o);
				assert (err_link_rx_o === '0)
					else report_mismatch("reset_state_err", 32'h0, err_link_rx_o);
			end
			assert (gt_sys_reset_o === exp_sys)
				else report_mismatch("sys_reset_window", exp_sys, gt_sys_reset_o);
			assert (gt_data_reset_o === exp_data)
				else report_mismatch("data_reset_window", exp_data, gt_data_reset_o);
			assert (link_reset_b_o === link_pipe[2])
				else report_mismatch("link_reset_release", link_pipe[2], link_reset_b_o);
			assert (phy_ready_o === (ready_run == READY_SAT))
				else report_mismatch("phy_ready_filter", ready_run == READY_SAT, phy_ready_o);
			assert (usedw_o === exp_usedw)
				else report_mismatch("status_usedw", exp_usedw, usedw_o);
			assert (err_link_rx_o === exp_err)
				else report_mismatch("status_err", exp_err, err_link_rx_o);
		end
	end

	initial begin : watchdog
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge rst_ctl_clk);
		end
		$display("Timeout: stimulus still running after %0d cycles", cycle_cnt);
		$display("Checks: %0d, errors: %0d", checks, errors);
		$display("Finished with errors");
		$finish;
	end

	////////////////////////////////
	// Stimulus
	////////////////////////////////

	task automatic cycle_power_good();
		gt_powergood_i = 1'b1;
		wait_cycles(240);
		gt_powergood_i = 1'b0;
		wait_cycles(4);
		gt_powergood_i = 1'b1;
		// Drop again inside the system reset window
		wait_cycles(105);
		gt_powergood_i = 1'b0;
		wait_cycles(3);
		gt_powergood_i = 1'b1;
		wait_cycles(240);
	endtask

	task automatic pulse_done_flags();
		tx_reset_done_i = 1'b1;
		rx_reset_done_i = 1'b1;
		wait_cycles(10);
		for (int f = 0; f < 3; f++) begin
			tx_reset_done_i = (f != 0);
			rx_reset_done_i = (f != 1);
			gt_powergood_i  = (f != 2);
			wait_cycles(6);
			tx_reset_done_i = 1'b1;
			rx_reset_done_i = 1'b1;
			gt_powergood_i  = 1'b1;
			wait_cycles(6);
		end
	endtask

	task automatic drop_ready_lanes();
		int bit_sel;
		for (int b = 0; b < READY_BURSTS; b++) begin
			tx_ready_i = '1;
			rx_ready_i = '1;
			wait_cycles(rand_between(20, 119));
			// Knock out one lane of one direction
			bit_sel = rand_between(0, 2 * NUM_LANES - 1);
			if (bit_sel < NUM_LANES) begin
				tx_ready_i[bit_sel] = 1'b0;
			end else begin
				rx_ready_i[bit_sel - NUM_LANES] = 1'b0;
			end
			wait_cycles(rand_between(1, 3));
		end
	endtask

	task automatic sweep_channel_codes();
		for (int i = 0; i < STATUS_CYCLES; i++) begin
			rx_channel_i = CHAN_W'($random(seed));
			for (int l = 0; l < NUM_LANES; l++) begin
				lane_usedw_i[l] = USEDW_W'($random(seed));
				lane_err_i[l]   = ERR_CNT_W'($random(seed));
			end
			// Short link reset in the middle of the readout
			tx_reset_done_i = !(i >= 150 && i < 156);
			wait_cycles(1);
		end
	endtask

	initial begin
		gt_powergood_i  = 1'b0;
		tx_reset_done_i = 1'b0;
		rx_reset_done_i = 1'b0;
		tx_ready_i      = '0;
		rx_ready_i      = '0;
		rx_channel_i    = '0;
		lane_usedw_i    = '0;
		lane_err_i      = '0;

		@(posedge pll_locked);
		wait_cycles(2);
		cycle_power_good();
		pulse_done_flags();
		drop_ready_lanes();
		sweep_channel_codes();
		wait_cycles(4);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// File: src/gt_reset_if.sv
// Transceiver reset controls and reset status, shared by the sequencer and the release monitor
`timescale 1ns/100ps

interface gt_reset_if;

	// Reset windows toward the transceivers
	logic gt_sys_reset;
	logic gt_data_reset;

	// Status reported back by the transceivers
	logic gt_powergood;
	logic tx_reset_done;
	logic rx_reset_done;

	// Reset sequencer side
	modport seq (
		output gt_sys_reset,
		output gt_data_reset,
		input  gt_powergood
	);

	// Link reset monitor only watches status
	modport mon (
		input  tx_reset_done,
		input  rx_reset_done,
		input  gt_powergood
	);

endinterface

// File: src/jesd_ctl_pkg.sv
// Shared constants of the JESD204B link control block, imported by every RTL unit
package jesd_ctl_pkg;

	////////////////////////////////
	// Link geometry
	////////////////////////////////

	// Lanes handled by the status logic
	localparam int NUM_LANES = 4;

	////////////////////////////////
	// PHY reset sequencing
	////////////////////////////////

	// Counter runs from release of PLL lock and power good
	localparam int RST_CNT_W = 16;

	// System reset window, inclusive counter values
	localparam logic [RST_CNT_W-1:0] SYS_RST_START = RST_CNT_W'(100);
	localparam logic [RST_CNT_W-1:0] SYS_RST_END   = RST_CNT_W'(110);

	// Data reset window follows once the system reset is over
	localparam logic [RST_CNT_W-1:0] DATA_RST_START = RST_CNT_W'(200);
	localparam logic [RST_CNT_W-1:0] DATA_RST_END   = RST_CNT_W'(210);

	// Done flags cross into rst_ctl_clk through this many flops
	localparam int SYNC_STAGES = 2;

	////////////////////////////////
	// Ready filter and lane status
	////////////////////////////////

	// Saturates at 63 unbroken ready cycles
	localparam int READY_CNT_W = 6;

	// Lane buffer fill level and error counter widths
	localparam int USEDW_W   = 10;
	localparam int ERR_CNT_W = 32;

	// One-based channel select code
	localparam int CHAN_W = 4;

endpackage

// File: src/jesd_link_ctl.sv
// Top level of the JESD204B link control block, wiring reset sequencing, release, ready and status units
`timescale 1ns/100ps

module jesd_link_ctl (
	// Control clock and PLL lock
	input  logic                                                          rst_ctl_clk,
	input  logic                                                          pll_locked,

	// Transceiver reset control and status
	input  logic                                                          gt_powergood_i,
	input  logic                                                          tx_reset_done_i,
	input  logic                                                          rx_reset_done_i,
	output logic                                                          gt_sys_reset_o,
	output logic                                                          gt_data_reset_o,
	output logic                                                          link_reset_b_o,

	// Lane ready flags
	input  logic [jesd_ctl_pkg::NUM_LANES-1:0]                            tx_ready_i,
	input  logic [jesd_ctl_pkg::NUM_LANES-1:0]                            rx_ready_i,
	output logic                                                          phy_ready_o,

	// Lane status readout
	input  logic [jesd_ctl_pkg::CHAN_W-1:0]                               rx_channel_i,
	input  logic [jesd_ctl_pkg::NUM_LANES-1:0][jesd_ctl_pkg::USEDW_W-1:0]   lane_usedw_i,
	input  logic [jesd_ctl_pkg::NUM_LANES-1:0][jesd_ctl_pkg::ERR_CNT_W-1:0] lane_err_i,
	output logic [jesd_ctl_pkg::USEDW_W-1:0]                              usedw_o,
	output logic [jesd_ctl_pkg::ERR_CNT_W-1:0]                            err_link_rx_o
);

	logic link_reset_b;

	//////////////////////////////
	// Transceiver reset bus
	//////////////////////////////

	gt_reset_if gt_bus ();

	// Status comes straight from the transceiver ports
	assign gt_bus.gt_powergood  = gt_powergood_i;
	assign gt_bus.tx_reset_done = tx_reset_done_i;
	assign gt_bus.rx_reset_done = rx_reset_done_i;

	assign gt_sys_reset_o  = gt_bus.gt_sys_reset;
	assign gt_data_reset_o = gt_bus.gt_data_reset;

	//////////////////////////////
	// Reset sequencing
	//////////////////////////////

	phy_reset_seq phy_reset_seq_inst (
		.rst_ctl_clk   (rst_ctl_clk),
		.pll_locked    (pll_locked),
		.gt            (gt_bus)
	);

	link_reset_ctl link_reset_ctl_inst (
		.rst_ctl_clk    (rst_ctl_clk),
		.pll_locked     (pll_locked),
		.gt             (gt_bus),
		.link_reset_b_o (link_reset_b)
	);

	assign link_reset_b_o = link_reset_b;

	//////////////////////////////
	// PHY ready to software
	//////////////////////////////

	phy_ready_filter phy_ready_filter_inst (
		.rst_ctl_clk   (rst_ctl_clk),
		.pll_locked    (pll_locked),
		.tx_ready_i    (tx_ready_i),
		.rx_ready_i    (rx_ready_i),
		.phy_ready_o   (phy_ready_o)
	);

	//////////////////////////////
	// Lane status readout
	//////////////////////////////

	// Readout stays cleared until the link is out of reset
	lane_status_select lane_status_select_inst (
		.rst_ctl_clk    (rst_ctl_clk),
		.pll_locked     (pll_locked),
		.link_reset_b_i (link_reset_b),
		.rx_channel_i   (rx_channel_i),
		.lane_usedw_i   (lane_usedw_i),
		.lane_err_i     (lane_err_i),
		.usedw_o        (usedw_o),
		.err_link_rx_o  (err_link_rx_o)
	);

endmodule

// File: src/lane_status_select.sv
// Lane status readout registering the fill level and error count of the lane picked by the channel code
`timescale 1ns/100ps

module lane_status_select (
	input  logic                                                      rst_ctl_clk,
	input  logic                                                      pll_locked,
	input  logic                                                      link_reset_b_i,
	input  logic [jesd_ctl_pkg::CHAN_W-1:0]                           rx_channel_i,
	input  logic [jesd_ctl_pkg::NUM_LANES-1:0][jesd_ctl_pkg::USEDW_W-1:0]   lane_usedw_i,
	input  logic [jesd_ctl_pkg::NUM_LANES-1:0][jesd_ctl_pkg::ERR_CNT_W-1:0] lane_err_i,
	output logic [jesd_ctl_pkg::USEDW_W-1:0]                          usedw_o,
	output logic [jesd_ctl_pkg::ERR_CNT_W-1:0]                        err_link_rx_o
);

	import jesd_ctl_pkg::*;

	logic                 sel_rst_b;
	logic [USEDW_W-1:0]   sel_usedw;
	logic [ERR_CNT_W-1:0] sel_err;

	//////////////////////////////
	// Channel decode
	//////////////////////////////

	// Code 1 is lane 0, codes outside 1..NUM_LANES read as zero
	always_comb begin
		sel_usedw = '0;
		sel_err   = '0;
		for (int i = 0; i < NUM_LANES; i++) begin
			if (rx_channel_i == CHAN_W'(i + 1)) begin
				sel_usedw = lane_usedw_i[i];
				sel_err   = lane_err_i[i];
			end
		end
	end

	//////////////////////////////
	// Output registers
	//////////////////////////////

	// Held clear while the link itself is in reset
	assign sel_rst_b = pll_locked & link_reset_b_i;

	always_ff @(posedge rst_ctl_clk or negedge sel_rst_b) begin
		if (!sel_rst_b) begin
			usedw_o       <= '0;
			err_link_rx_o <= '0;
		end else begin
			usedw_o       <= sel_usedw;
			err_link_rx_o <= sel_err;
		end
	end

endmodule

// File: src/link_reset_ctl.sv
// Link reset release, synchronizing transceiver done flags and power good into rst_ctl_clk
`timescale 1ns/100ps

module link_reset_ctl (
	input  logic  rst_ctl_clk,
	input  logic  pll_locked,
	gt_reset_if.mon gt,
	output logic  link_reset_b_o
);

	import jesd_ctl_pkg::*;

	// Flag order in the synchronizer word
	localparam int FLAG_TX = 0;
	localparam int FLAG_RX = 1;
	localparam int FLAG_PG = 2;

	logic [2:0]                  flags_async;
	logic [SYNC_STAGES-1:0][2:0] sync_q;
	logic                        all_up;
	logic                        link_reset_b_q;

	assign flags_async[FLAG_TX] = gt.tx_reset_done;
	assign flags_async[FLAG_RX] = gt.rx_reset_done;
	assign flags_async[FLAG_PG] = gt.gt_powergood;

	//////////////////////////////
	// Synchronizer
	//////////////////////////////

	// Stage 0 samples the raw flags, last stage feeds the AND
	always_ff @(posedge rst_ctl_clk or negedge pll_locked) begin
		if (!pll_locked) begin
			sync_q <= '0;
		end else begin
			sync_q <= {sync_q[SYNC_STAGES-2:0], flags_async};
		end
	end

	assign all_up = &sync_q[SYNC_STAGES-1];

	//////////////////////////////
	// Link reset
	//////////////////////////////

	always_ff @(posedge rst_ctl_clk or negedge pll_locked) begin
		if (!pll_locked) begin
			link_reset_b_q <= 1'b0;
		end else begin
			link_reset_b_q <= all_up;
		end
	end

	assign link_reset_b_o = link_reset_b_q;

endmodule

// File: src/phy_ready_filter.sv
// PHY ready qualifier raising the software flag after a long unbroken all-lanes-ready stretch
`timescale 1ns/100ps

module phy_ready_filter (
	input  logic                                rst_ctl_clk,
	input  logic                                pll_locked,
	input  logic [jesd_ctl_pkg::NUM_LANES-1:0]  tx_ready_i,
	input  logic [jesd_ctl_pkg::NUM_LANES-1:0]  rx_ready_i,
	output logic                                phy_ready_o
);

	import jesd_ctl_pkg::*;

	logic                   ready_ena;
	logic [READY_CNT_W-1:0] ready_cnt;

	// Every TX and RX lane must be ready
	assign ready_ena = (&tx_ready_i) & (&rx_ready_i);

	//////////////////////////////
	// Qualification counter
	//////////////////////////////

	always_ff @(posedge rst_ctl_clk or negedge pll_locked) begin
		if (!pll_locked) begin
			ready_cnt <= '0;
		end else begin
			if (ready_ena) begin
				// Hold at all ones once qualified
				ready_cnt <= ready_cnt + READY_CNT_W'(!(&ready_cnt));
			end else begin
				// Any gap starts the count over
				ready_cnt <= '0;
			end
		end
	end

	// Saturated count means ready
	assign phy_ready_o = &ready_cnt;

endmodule

// File: src/phy_reset_seq.sv
// Transceiver reset sequencer timing the system and data reset windows after PLL lock and power good
`timescale 1ns/100ps

module phy_reset_seq (
	input  logic  rst_ctl_clk,
	input  logic  pll_locked,
	gt_reset_if.seq gt
);

	import jesd_ctl_pkg::*;

	logic                 cnt_rst_b;
	logic [RST_CNT_W-1:0] rst_cnt;
	logic                 sys_rst_win;
	logic                 data_rst_win;
	logic                 sys_rst_q;
	logic                 data_rst_q;

	//////////////////////////////
	// Release counter
	//////////////////////////////

	// Loss of lock or of power good restarts the sequence
	assign cnt_rst_b = pll_locked & gt.gt_powergood;

	always_ff @(posedge rst_ctl_clk or negedge cnt_rst_b) begin
		if (!cnt_rst_b) begin
			rst_cnt <= '0;
		end else begin
			// Stops at all ones
			rst_cnt <= rst_cnt + RST_CNT_W'(!(&rst_cnt));
		end
	end

	//////////////////////////////
	// Reset windows
	//////////////////////////////

	assign sys_rst_win  = (rst_cnt >= SYS_RST_START) && (rst_cnt <= SYS_RST_END);
	assign data_rst_win = (rst_cnt >= DATA_RST_START) && (rst_cnt <= DATA_RST_END);

	// One edge behind the counter
	always_ff @(posedge rst_ctl_clk or negedge pll_locked) begin
		if (!pll_locked) begin
			sys_rst_q  <= 1'b0;
			data_rst_q <= 1'b0;
		end else begin
			sys_rst_q  <= sys_rst_win;
			data_rst_q <= data_rst_win;
		end
	end

	assign gt.gt_sys_reset  = sys_rst_q;
	assign gt.gt_data_reset = data_rst_q;

endmodule

// File: verilog.f
src/jesd_ctl_pkg.sv
src/gt_reset_if.sv
src/phy_reset_seq.sv
src/link_reset_ctl.sv
src/phy_ready_filter.sv
src/lane_status_select.sv
src/jesd_link_ctl.sv
bench/tb_clock_gen.sv
bench/tb_jesd_link_ctl.sv
